//--- all.f
+incdir+rtl
rtl/syscfg_pkg.sv
rtl/syscfg_reg_if.sv
rtl/syscfg_apb_decode.sv
rtl/syscfg_pause_seq.sv
rtl/syscfg_tgt.sv
rtl/syscfg_top.sv
verif/syscfg_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module syscfg_tb -o syscfg_sim
./obj_dir/syscfg_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi

//--- verif/syscfg_tb.sv
`timescale 1ns/100ps
`include "syscfg_config.svh"

module syscfg_tb;

    localparam int TIMEOUT = 64; // Cycles allowed for any one wait.

    logic clk, reset, psel, penable, pwrite, pready, pslverr, pause_req, pause_ack;
    syscfg_pkg::addr_t paddr;
    syscfg_pkg::data_t pwdata, prdata;
    syscfg_pkg::data_t cpu_boot_addr [`SYSCFG_NO_CPUS];
    logic [`SYSCFG_NO_CPUS-1:0] cpu_rst, cpu_pause_req, cpu_irq;
    logic [`SYSCFG_NO_CPUS-1:0] cpu_pause_ack = '0;
    logic [`SYSCFG_NO_DMAS-1:0] dma_rst, dma_pause_req, dma_irq;
    logic [`SYSCFG_NO_DMAS-1:0] dma_pause_ack = '0;
    logic [`SYSCFG_NO_LSPS-1:0] lsp_rst, lsp_pause_req, lsp_irq;
    logic [`SYSCFG_NO_LSPS-1:0] lsp_pause_ack = '0;
    logic [`SYSCFG_NO_TGTS-1:0] all_rst, all_pause_req;
    syscfg_pkg::ctrl_t exp_ctrl [`SYSCFG_NO_TGTS]; // What each window's CTRL should hold.
    int seed = 23;
    int mismatches = 0;
    int failures = 0;

    syscfg_top dut_i (.*);

    assign all_rst       = {lsp_rst, dma_rst, cpu_rst}; // Window order.
    assign all_pause_req = {lsp_pause_req, dma_pause_req, cpu_pause_req};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Every target answers its pause request one cycle later.
    always @(posedge clk) begin
        cpu_pause_ack <= cpu_pause_req;
        dma_pause_ack <= dma_pause_req;
        lsp_pause_ack <= lsp_pause_req;
    end

    task automatic check_data(input string name, input syscfg_pkg::data_t got, expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_bit(input string name, input logic got, expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic check_ctrl(input string name, input syscfg_pkg::ctrl_t got, expected);
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, expected);
        end
    endtask

    function automatic syscfg_pkg::addr_t reg_addr(input int win,
                                                   input syscfg_pkg::reg_offset_e off);
        return syscfg_pkg::addr_t'(win * 16 + int'(off) * 4); // 16-byte windows.
    endfunction

    task automatic apb_access(input logic is_write, input syscfg_pkg::addr_t addr,
                              input syscfg_pkg::data_t wdata,
                              output syscfg_pkg::data_t rdata, output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= is_write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (pready !== 1'b1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pready !== 1'b1) begin
            failures++;
            $display("APB access to %h got no pready within %0d cycles", addr, TIMEOUT);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk); // Transfer completes on this edge.
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input syscfg_pkg::addr_t addr, input syscfg_pkg::data_t data);
        syscfg_pkg::data_t ignored_rdata;
        logic              ignored_err;
        apb_access(1'b1, addr, data, ignored_rdata, ignored_err);
    endtask

    task automatic apb_read(input syscfg_pkg::addr_t addr, output syscfg_pkg::data_t rdata,
                            output logic err);
        apb_access(1'b0, addr, '0, rdata, err);
    endtask

    task automatic set_ctrl(input int win, input syscfg_pkg::ctrl_t c);
        apb_write(reg_addr(win, syscfg_pkg::REG_CTRL), {{(`SYSCFG_DATA_WIDTH-2){1'b0}}, c});
        exp_ctrl[win] = c;
    endtask

    // Reads back CTRL and compares it, and the rst and pause_req outputs, with the model.
    task automatic check_window(input int win);
        syscfg_pkg::data_t rd;
        logic              err;
        apb_read(reg_addr(win, syscfg_pkg::REG_CTRL), rd, err);
        check_bit($sformatf("pslverr[%0d]", win), err, 1'b0);
        check_ctrl($sformatf("ctrl[%0d]", win), rd[1:0], exp_ctrl[win]);
        @(negedge clk);
        check_ctrl($sformatf("outputs[%0d]", win), {all_pause_req[win], all_rst[win]},
                   exp_ctrl[win]);
    endtask

    task automatic wait_pause_ack(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pause_ack !== level && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (pause_ack !== level) begin
            failures++;
            $display("pause_ack did not go to %b within %0d cycles", level, TIMEOUT);
        end
    endtask

    task automatic test_reset_values();
        syscfg_pkg::data_t rd;
        logic              err;
        for (int w = 0; w < `SYSCFG_NO_TGTS; w++) begin
            check_window(w);
        end
        for (int c = 0; c < `SYSCFG_NO_CPUS; c++) begin
            apb_read(reg_addr(`SYSCFG_CPU_BASE + c, syscfg_pkg::REG_BOOT_ADDR), rd, err);
            check_data($sformatf("boot_addr[%0d]", c), rd, `SYSCFG_BOOT_ADDR_RESET);
            check_data($sformatf("cpu_boot_addr[%0d]", c), cpu_boot_addr[c],
                       `SYSCFG_BOOT_ADDR_RESET);
        end
    endtask

    task automatic test_registers();
        syscfg_pkg::data_t rd;
        syscfg_pkg::data_t boot;
        logic              err;
        boot = $random(seed);
        set_ctrl(1, '{pause: 1'b0, rst: 1'b0});
        set_ctrl(`SYSCFG_LSP_BASE, '{pause: 1'b1, rst: 1'b0});
        check_window(1);
        check_window(`SYSCFG_LSP_BASE);
        apb_write(reg_addr(1, syscfg_pkg::REG_BOOT_ADDR), boot);
        apb_read(reg_addr(1, syscfg_pkg::REG_BOOT_ADDR), rd, err);
        check_data("boot_addr[1]", rd, boot);
        check_data("cpu_boot_addr[1]", cpu_boot_addr[1], boot);
        // Peripheral windows have neither register.
        apb_write(reg_addr(`SYSCFG_LSP_BASE, syscfg_pkg::REG_BOOT_ADDR), boot);
        apb_write(reg_addr(`SYSCFG_LSP_BASE, syscfg_pkg::REG_IRQ_MASK), boot);
        apb_read(reg_addr(`SYSCFG_LSP_BASE, syscfg_pkg::REG_BOOT_ADDR), rd, err);
        check_data("lsp boot_addr", rd, '0);
        apb_read(reg_addr(`SYSCFG_LSP_BASE, syscfg_pkg::REG_IRQ_MASK), rd, err);
        check_data("lsp irq_mask", rd, '0);
        apb_read(reg_addr(`SYSCFG_NO_TGTS, syscfg_pkg::REG_CTRL), rd, err);
        check_bit("pslverr out of range", err, 1'b1);
        check_data("prdata out of range", rd, '0);
    endtask

    task automatic test_irq();
        syscfg_pkg::data_t cpu_mask;
        syscfg_pkg::data_t dma_mask;
        cpu_mask = $random(seed);
        dma_mask = $random(seed);
        apb_write(reg_addr(1, syscfg_pkg::REG_IRQ_MASK), cpu_mask);
        apb_write(reg_addr(`SYSCFG_DMA_BASE, syscfg_pkg::REG_IRQ_MASK), dma_mask);
        for (int i = 0; i < 12; i++) begin
            @(posedge clk);
            lsp_irq <= `SYSCFG_NO_LSPS'($random(seed));
            repeat (2) @(negedge clk); // One register stage to settle.
            // Only the low bits of the vector carry lines.
            check_bit("cpu_irq[1]", cpu_irq[1], |(lsp_irq & cpu_mask[`SYSCFG_NO_LSPS-1:0]));
            check_bit("dma_irq[0]", dma_irq[0], |(lsp_irq & dma_mask[`SYSCFG_NO_LSPS-1:0]));
            check_bit("cpu_irq[0]", cpu_irq[0], 1'b0);
        end
    endtask

    task automatic test_status();
        syscfg_pkg::data_t rd;
        logic              err;
        set_ctrl(1, '{pause: 1'b1, rst: 1'b0});
        @(negedge clk);
        check_bit("cpu_pause_req[1]", cpu_pause_req[1], 1'b1);
        // The target's acknowledge shows in STATUS one cycle late.
        apb_read(reg_addr(1, syscfg_pkg::REG_STATUS), rd, err);
        check_data("status[1] own pause", rd, syscfg_pkg::data_t'(1));
        set_ctrl(1, '{pause: 1'b0, rst: 1'b0});
        check_window(1);
        apb_read(reg_addr(1, syscfg_pkg::REG_STATUS), rd, err);
        check_data("status[1] released", rd, '0);
    endtask

    task automatic test_system_pause();
        syscfg_pkg::data_t rd;
        logic              err;
        logic              read_done;
        read_done = 1'b0;
        @(posedge clk);
        pause_req <= 1'b1;
        wait_pause_ack(1'b1);
        check_bit("all pause_req during pause", &all_pause_req, 1'b1);
        fork
            begin
                apb_read(reg_addr(1, syscfg_pkg::REG_CTRL), rd, err);
                read_done = 1'b1;
            end
            begin
                repeat (10) @(negedge clk);
                check_bit("read done during pause", read_done, 1'b0);
                @(posedge clk);
                pause_req <= 1'b0;
                wait_pause_ack(1'b0);
            end
        join
        check_ctrl("ctrl[1] read across pause", rd[1:0], exp_ctrl[1]);
        for (int w = 0; w < `SYSCFG_NO_TGTS; w++) begin
            check_window(w);
        end
    endtask

    initial begin
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pause_req = 1'b0;
        lsp_irq   = '0;
        for (int w = 0; w < `SYSCFG_NO_TGTS; w++) begin
            exp_ctrl[w] = (w == 0) ? 2'b00 : 2'b11; // Only CPU 0 boots on its own.
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_registers();
        test_irq();
        test_status();
        test_system_pause();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- rtl/syscfg_top.sv
`timescale 1ns/100ps
`include "syscfg_config.svh"

module syscfg_top (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  syscfg_pkg::addr_t         paddr,
    input  syscfg_pkg::data_t         pwdata,
    output syscfg_pkg::data_t         prdata,
    output logic                      pready,
    output logic                      pslverr,

    input  logic                      pause_req,
    output logic                      pause_ack,

    output logic [`SYSCFG_NO_CPUS-1:0] cpu_rst,
    output logic [`SYSCFG_NO_CPUS-1:0] cpu_pause_req,
    input  logic [`SYSCFG_NO_CPUS-1:0] cpu_pause_ack,
    output syscfg_pkg::data_t          cpu_boot_addr [`SYSCFG_NO_CPUS],
    output logic [`SYSCFG_NO_CPUS-1:0] cpu_irq,

    output logic [`SYSCFG_NO_DMAS-1:0] dma_rst,
    output logic [`SYSCFG_NO_DMAS-1:0] dma_pause_req,
    input  logic [`SYSCFG_NO_DMAS-1:0] dma_pause_ack,
    output logic [`SYSCFG_NO_DMAS-1:0] dma_irq,

    output logic [`SYSCFG_NO_LSPS-1:0] lsp_rst,
    output logic [`SYSCFG_NO_LSPS-1:0] lsp_pause_req,
    input  logic [`SYSCFG_NO_LSPS-1:0] lsp_pause_ack,
    input  logic [`SYSCFG_NO_LSPS-1:0] lsp_irq
);

    syscfg_pkg::data_t          irq_vec;
    logic                       bus_hold;
    logic                       bus_idle;
    logic                       sys_pause;
    logic [`SYSCFG_NO_TGTS-1:0] paused;

    syscfg_reg_if regs [`SYSCFG_NO_TGTS] ();

    // Peripheral lines sit at the bottom of the shared vector.
    assign irq_vec = {{(`SYSCFG_DATA_WIDTH-`SYSCFG_NO_LSPS){1'b0}}, lsp_irq};

    syscfg_apb_decode apb_decode_i (
        .clk, .reset,
        .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .bus_hold, .bus_idle,
        .regs (regs)
    );

    syscfg_pause_seq pause_seq_i (
        .clk, .reset,
        .pause_req, .pause_ack,
        .bus_hold, .bus_idle,
        .sys_pause, .paused
    );

    for (genvar i = 0; i < `SYSCFG_NO_CPUS; i++) begin : g_cpu
        syscfg_tgt #(
            .EN_BOOTSTRAP (i == 0), // CPU 0 runs out of reset.
            .EN_BOOT_ADDR (1),
            .EN_IRQ       (1)
        ) tgt_cpu_i (
            .clk, .reset,
            .regs          (regs[`SYSCFG_CPU_BASE+i]),
            .irq_vec, .sys_pause,
            .paused        (paused[`SYSCFG_CPU_BASE+i]),
            .tgt_rst       (cpu_rst[i]),
            .tgt_pause_req (cpu_pause_req[i]),
            .tgt_pause_ack (cpu_pause_ack[i]),
            .tgt_boot_addr (cpu_boot_addr[i]),
            .tgt_irq       (cpu_irq[i])
        );
    end

    for (genvar i = 0; i < `SYSCFG_NO_DMAS; i++) begin : g_dma
        syscfg_tgt #(.EN_BOOTSTRAP (0), .EN_BOOT_ADDR (0), .EN_IRQ (1)) tgt_dma_i (
            .clk, .reset,
            .regs          (regs[`SYSCFG_DMA_BASE+i]),
            .irq_vec, .sys_pause,
            .paused        (paused[`SYSCFG_DMA_BASE+i]),
            .tgt_rst       (dma_rst[i]),
            .tgt_pause_req (dma_pause_req[i]),
            .tgt_pause_ack (dma_pause_ack[i]),
            .tgt_boot_addr (),
            .tgt_irq       (dma_irq[i])
        );
    end

    for (genvar i = 0; i < `SYSCFG_NO_LSPS; i++) begin : g_lsp
        syscfg_tgt #(.EN_BOOTSTRAP (0), .EN_BOOT_ADDR (0), .EN_IRQ (0)) tgt_lsp_i (
            .clk, .reset,
            .regs          (regs[`SYSCFG_LSP_BASE+i]),
            .irq_vec, .sys_pause,
            .paused        (paused[`SYSCFG_LSP_BASE+i]),
            .tgt_rst       (lsp_rst[i]),
            .tgt_pause_req (lsp_pause_req[i]),
            .tgt_pause_ack (lsp_pause_ack[i]),
            .tgt_boot_addr (),
            .tgt_irq       ()
        );
    end

endmodule

//--- rtl/syscfg_tgt.sv
`timescale 1ns/100ps
`include "syscfg_config.svh"

module syscfg_tgt #(
    parameter bit EN_BOOTSTRAP = 0,
    parameter bit EN_BOOT_ADDR = 0,
    parameter bit EN_IRQ       = 0
) (
    input  logic              clk,
    input  logic              reset,

    syscfg_reg_if.tgt         regs,

    input  syscfg_pkg::data_t irq_vec,

    input  logic              sys_pause,
    output logic              paused,

    output logic              tgt_rst,
    output logic              tgt_pause_req,
    input  logic              tgt_pause_ack,
    output syscfg_pkg::data_t tgt_boot_addr,
    output logic              tgt_irq
);

    localparam syscfg_pkg::ctrl_t CTRL_RESET =
        EN_BOOTSTRAP ? syscfg_pkg::CTRL_RELEASED : syscfg_pkg::CTRL_HELD;

    syscfg_pkg::ctrl_t ctrl_q;
    syscfg_pkg::data_t boot_addr;
    syscfg_pkg::data_t irq_mask;
    syscfg_pkg::data_t rdata;
    logic              status_q;
    logic              paused_level;
    logic              wr_en;

    assign wr_en = regs.sel & regs.write;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q   <= CTRL_RESET;
            status_q <= 1'b0;
        end else begin
            if (wr_en && regs.offset == syscfg_pkg::REG_CTRL) begin
                ctrl_q <= syscfg_pkg::ctrl_t'(regs.wdata[1:0]);
            end
            status_q <= paused_level;
        end
    end

    if (EN_BOOT_ADDR) begin : g_boot_addr
        syscfg_pkg::data_t boot_addr_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                boot_addr_q <= `SYSCFG_BOOT_ADDR_RESET;
            end else if (wr_en && regs.offset == syscfg_pkg::REG_BOOT_ADDR) begin
                boot_addr_q <= regs.wdata;
            end
        end
        assign boot_addr = boot_addr_q;
    end else begin : g_no_boot_addr
        assign boot_addr = '0;
    end

    if (EN_IRQ) begin : g_irq
        syscfg_pkg::data_t irq_mask_q;
        logic              irq_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                irq_mask_q <= '0;
                irq_q      <= 1'b0;
            end else begin
                if (wr_en && regs.offset == syscfg_pkg::REG_IRQ_MASK) irq_mask_q <= regs.wdata;
                irq_q <= |(irq_vec & irq_mask_q);
            end
        end
        assign irq_mask = irq_mask_q;
        assign tgt_irq  = irq_q;
    end else begin : g_no_irq
        assign irq_mask = '0;
        assign tgt_irq  = 1'b0;
    end

    always_comb begin
        rdata = '0;
        case (regs.offset)
            syscfg_pkg::REG_CTRL:      rdata[1:0] = ctrl_q;
            syscfg_pkg::REG_STATUS:    rdata[0]   = status_q;
            syscfg_pkg::REG_BOOT_ADDR: rdata      = boot_addr;
            syscfg_pkg::REG_IRQ_MASK:  rdata      = irq_mask;
            default:                   rdata      = '0;
        endcase
    end

    assign regs.rdata = rdata;

    assign tgt_rst       = ctrl_q.rst;
    assign tgt_pause_req = ctrl_q.pause | sys_pause;
    assign tgt_boot_addr = boot_addr;

    // A target held in reset cannot answer, so it counts as paused for a
    // system pause.
    assign paused_level = tgt_pause_ack | (sys_pause & ctrl_q.rst);

    // A target kept paused by its own CTRL does not hold up the release.
    assign paused = paused_level & (sys_pause | ~ctrl_q.pause);

endmodule

//--- rtl/syscfg_pause_seq.sv
`timescale 1ns/100ps
`include "syscfg_config.svh"

module syscfg_pause_seq (
    input  logic                       clk,
    input  logic                       reset,

    input  logic                       pause_req,
    output logic                       pause_ack,

    output logic                       bus_hold,
    input  logic                       bus_idle,

    output logic                       sys_pause,
    input  logic [`SYSCFG_NO_TGTS-1:0] paused
);

    typedef enum logic [2:0] {
        RUN,
        HOLD_BUS,
        HOLD_TGTS,
        PAUSED,
        RELEASE_TGTS,
        RELEASE_BUS
    } state_e;

    state_e state;

    // A request withdrawn before the acknowledge unwinds the same way,
    // with pause_ack staying low.
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RUN;
            pause_ack <= 1'b0;
        end else begin
            case (state)
                RUN:          if (pause_req) state <= HOLD_BUS;
                HOLD_BUS: begin
                    if (!pause_req)    state <= RELEASE_BUS;
                    else if (bus_idle) state <= HOLD_TGTS;
                end
                HOLD_TGTS: begin
                    if (!pause_req) begin
                        state <= RELEASE_TGTS;
                    end else if (&paused) begin
                        state     <= PAUSED;
                        pause_ack <= 1'b1;
                    end
                end
                PAUSED:       if (!pause_req) state <= RELEASE_TGTS;
                RELEASE_TGTS: if (~|paused) state <= RELEASE_BUS;
                RELEASE_BUS: begin
                    if (!bus_idle) begin
                        state     <= RUN;
                        pause_ack <= 1'b0;
                    end
                end
                default:      state <= RUN;
            endcase
        end
    end

    assign bus_hold  = (state == HOLD_BUS) || (state == HOLD_TGTS) ||
                       (state == PAUSED) || (state == RELEASE_TGTS);
    assign sys_pause = (state == HOLD_TGTS) || (state == PAUSED);

endmodule

//--- rtl/syscfg_apb_decode.sv
`timescale 1ns/100ps
`include "syscfg_config.svh"

module syscfg_apb_decode (
    input  logic              clk,
    input  logic              reset,

    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  syscfg_pkg::addr_t paddr,
    input  syscfg_pkg::data_t pwdata,
    output syscfg_pkg::data_t prdata,
    output logic              pready,
    output logic              pslverr,

    input  logic              bus_hold,
    output logic              bus_idle,

    syscfg_reg_if.decode      regs [`SYSCFG_NO_TGTS]
);

    syscfg_pkg::tgt_idx_t idx;
    syscfg_pkg::data_t    rdata_win [`SYSCFG_NO_TGTS];
    logic                 access;
    logic                 in_range;
    logic                 frozen;

    assign idx      = syscfg_pkg::tgt_idx_t'(paddr[7:4]);
    assign in_range = (idx < syscfg_pkg::tgt_idx_t'(`SYSCFG_NO_TGTS));
    assign access   = psel & penable;

    // The freeze lags bus_hold by one cycle, so an access phase already
    // under way when the hold arrives still completes.
    always_ff @(posedge clk) begin
        if (reset) frozen <= 1'b0;
        else       frozen <= bus_hold;
    end

    assign bus_idle = frozen; // No transfer can complete while frozen.
    assign pready   = access & ~frozen;
    assign pslverr  = pready & ~in_range;

    for (genvar i = 0; i < `SYSCFG_NO_TGTS; i++) begin : g_win
        assign regs[i].sel    = pready & (idx == syscfg_pkg::tgt_idx_t'(i));
        assign regs[i].write  = pwrite;
        assign regs[i].offset = syscfg_pkg::reg_offset_e'(paddr[3:2]);
        assign regs[i].wdata  = pwdata;
        assign rdata_win[i]   = regs[i].rdata;
    end

    // Out-of-range windows and idle cycles read as zero.
    always_comb begin
        prdata = '0;
        for (int i = 0; i < `SYSCFG_NO_TGTS; i++) begin
            if (access && idx == syscfg_pkg::tgt_idx_t'(i)) prdata = rdata_win[i];
        end
    end

endmodule

//--- rtl/syscfg_reg_if.sv
`timescale 1ns/100ps

// One completed register access, broadcast to a single target window.
interface syscfg_reg_if;

    logic                    sel;    // High for one cycle on the completing edge.
    logic                    write;
    syscfg_pkg::reg_offset_e offset;
    syscfg_pkg::data_t       wdata;
    syscfg_pkg::data_t       rdata;  // Combinational from the window.

    modport decode (
        output sel, write, offset, wdata,
        input  rdata
    );

    modport tgt (
        input  sel, write, offset, wdata,
        output rdata
    );

endinterface

//--- rtl/syscfg_pkg.sv
`include "syscfg_config.svh"

package syscfg_pkg;

    typedef logic [`SYSCFG_DATA_WIDTH-1:0] data_t;
    typedef logic [`SYSCFG_ADDR_WIDTH-1:0] addr_t;

    // Window number, taken from paddr[7:4].
    typedef logic [3:0] tgt_idx_t;

    // Word offset inside a 16-byte window, taken from paddr[3:2].
    typedef enum logic [1:0] {
        REG_CTRL      = 2'd0,
        REG_STATUS    = 2'd1,
        REG_BOOT_ADDR = 2'd2,
        REG_IRQ_MASK  = 2'd3
    } reg_offset_e;

    // Low two bits of CTRL.
    typedef struct packed {
        logic pause; // Bit 1.
        logic rst;   // Bit 0.
    } ctrl_t;

    localparam ctrl_t CTRL_RELEASED = '{pause: 1'b0, rst: 1'b0};
    localparam ctrl_t CTRL_HELD     = '{pause: 1'b1, rst: 1'b1};

endpackage

//--- rtl/syscfg_config.svh
`ifndef SYSCFG_CONFIG_SVH
`define SYSCFG_CONFIG_SVH

// Register word and APB address widths.
`define SYSCFG_DATA_WIDTH 32
`define SYSCFG_ADDR_WIDTH 16

// Managed targets, one register window each.
`define SYSCFG_NO_CPUS 2
`define SYSCFG_NO_DMAS 1
`define SYSCFG_NO_LSPS 4 // Also the number of interrupt lines.

`define SYSCFG_NO_TGTS (`SYSCFG_NO_CPUS + `SYSCFG_NO_DMAS + `SYSCFG_NO_LSPS)

// First window index of each target group.
`define SYSCFG_CPU_BASE 0
`define SYSCFG_DMA_BASE (`SYSCFG_CPU_BASE + `SYSCFG_NO_CPUS)
`define SYSCFG_LSP_BASE (`SYSCFG_DMA_BASE + `SYSCFG_NO_DMAS)

`define SYSCFG_BOOT_ADDR_RESET 32'h0000_1000 // Where CPUs fetch after reset.

`endif
